// File: power_pkg.sv
/*
 * Shared widths, interrupt cause numbers and the decoded interrupt word
 * for the sleep and clock-gating subsystem. Modules reach these through
 * a wildcard import of power_pkg in their module header.
 */
`default_nettype none

package power_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Pending and enable words carry one bit per interrupt cause
  localparam int IRQ_W    = 32;
  // An identity names one of the 32 causes
  localparam int IRQ_ID_W = 5;
  // Per-bus outstanding counter, so at most three transactions in flight
  localparam int OUTST_W  = 2;

  //////////////////////////////////////////////////
  // Interrupt cause numbers
  //////////////////////////////////////////////////

  // Standard machine-level causes
  localparam int IRQ_MSI = 3;
  localparam int IRQ_MTI = 7;
  localparam int IRQ_MEI = 11;
  // Fast line 0 lives at this cause, fast line 15 at the top bit
  localparam int FAST_LO = 16;

  // One interrupt word, read either as a flat vector or by field
  // The field layout mirrors the cause numbers above
  typedef union packed {
    logic [IRQ_W-1:0] flat;
    struct packed {
      logic [IRQ_W-FAST_LO-1:0] fast;
      logic [3:0]               rsvd_15_12;
      logic                     mei;
      logic [2:0]               rsvd_10_8;
      logic                     mti;
      logic [2:0]               rsvd_6_4;
      logic                     msi;
      logic [2:0]               rsvd_2_0;
    } field;
  } irq_word_u;

endpackage

`default_nettype wire

// File: clock_gate.sv
/*
 * Latch-based clock gate. The enable is captured while the clock is low,
 * so the gated clock never shows a partial pulse. Scan mode forces it on.
 * Kept on its own so that a technology cell can take its place.
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic scan_cg_en_i,
  output logic clk_o
);

  // Enable as seen by the AND gate, stable through the high phase
  logic en_latched;

  // Transparent while the clock is low and closed while it is high
  always_latch begin
    if (clk_i == 1'b0) begin
      en_latched = en_i | scan_cg_en_i;
    end
  end

  // A change of enable shows on the next rising edge of the output
  assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

// File: irq_wake_unit.sv
/*
 * Interrupt wake unit. Masks the pending word with the enable word,
 * raises wake when any enabled interrupt is pending and names the winner.
 * Purely combinational, so wake and identity follow the inputs directly.
 */
`timescale 1ns/1ps
`default_nettype none

module irq_wake_unit
  import power_pkg::*;
(
  input  logic [IRQ_W-1:0]    irq_i,
  input  logic [IRQ_W-1:0]    irq_enable_i,
  output logic                irq_wake_o,
  output logic [IRQ_ID_W-1:0] irq_id_o
);

  // Pending interrupts that are also enabled
  irq_word_u irq_masked;

  assign irq_masked.flat = irq_i & irq_enable_i;

  //////////////////////////////////////////////////
  // Wake and priority choice
  //////////////////////////////////////////////////

  // Wake comes from the flat view, the identity from the field view
  always_comb begin
    irq_wake_o = |irq_masked.flat;
    irq_id_o   = '0;

    if (|irq_masked.field.fast) begin
      // Ascending scan, so the highest-numbered fast line is the last
      // one written and therefore wins
      for (int i = 0; i < IRQ_W - FAST_LO; i++) begin
        if (irq_masked.field.fast[i]) begin
          irq_id_o = IRQ_ID_W'(FAST_LO + i);
        end
      end
    end else if (irq_masked.field.mei) begin
      // External comes first among the standard causes
      irq_id_o = IRQ_ID_W'(IRQ_MEI);
    end else if (irq_masked.field.msi) begin
      // Software ranks above timer
      irq_id_o = IRQ_ID_W'(IRQ_MSI);
    end else if (irq_masked.field.mti) begin
      irq_id_o = IRQ_ID_W'(IRQ_MTI);
    end

    // Reserved bits may wake the core but never produce an identity,
    // while a named identity must always come with wake
    a_id_needs_wake: assert ((irq_id_o == '0) || irq_wake_o)
      else $error("irq_wake_unit: identity %0d without wake", irq_id_o);
  end

endmodule

`default_nettype wire

// File: activity_monitor.sv
/*
 * Activity monitor. Counts outstanding instruction and data bus
 * transactions and merges them with the fetch and controller busy levels
 * into one combined busy level for the sleep controller.
 */
`timescale 1ns/1ps
`default_nettype none

module activity_monitor
  import power_pkg::*;
(
  input  logic clk_ungated_i,
  input  logic rst_n,
  input  logic if_busy_i,
  input  logic ctrl_busy_i,
  input  logic instr_req_i,
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic core_busy_o
);

  // Transactions granted but not yet answered, one counter per bus
  logic [OUTST_W-1:0] instr_outst_q;
  logic [OUTST_W-1:0] data_outst_q;

  // Grant alone counts up, valid alone counts down
  // Both together retire one and start one, so the count holds
  function automatic logic [OUTST_W-1:0] count_next(
    input logic [OUTST_W-1:0] cnt,
    input logic               inc,
    input logic               dec
  );
    logic [OUTST_W-1:0] nxt;
    nxt = cnt;
    if (inc && !dec) begin
      nxt = cnt + 1'b1;
    end else if (dec && !inc) begin
      nxt = cnt - 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Outstanding counters
  //////////////////////////////////////////////////

  // Counters run on the free clock so that a late valid is still seen
  always_ff @(posedge clk_ungated_i or negedge rst_n) begin
    if (!rst_n) begin
      instr_outst_q <= '0;
      data_outst_q  <= '0;
    end else begin
      instr_outst_q <= count_next(instr_outst_q, instr_gnt_i, instr_rvalid_i);
      data_outst_q  <= count_next(data_outst_q, data_gnt_i, data_rvalid_i);
    end
  end

  // A request without a grant carries no count yet, so it counts as busy
  // on its own
  assign core_busy_o = if_busy_i | ctrl_busy_i | instr_req_i | data_req_i |
                       (|instr_outst_q) | (|data_outst_q);

  // A response needs an open transaction, or a grant in the same cycle
  a_instr_no_underflow: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    (instr_rvalid_i && !instr_gnt_i) |-> (instr_outst_q != '0));
  a_data_no_underflow: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    (data_rvalid_i && !data_gnt_i) |-> (data_outst_q != '0));

  // The bus must not grant past the counter's range
  a_instr_no_overflow: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    instr_gnt_i |-> (instr_outst_q != '1));
  a_data_no_overflow: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    data_gnt_i |-> (data_outst_q != '1));

endmodule

`default_nettype wire

// File: sleep_ctrl.sv
/*
 * Sleep controller. Keeps a sticky fetch enable and a registered busy
 * level, forms the clock enable and the sleep flag from them and from the
 * wake level, and drives the core clock gate.
 */
`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  logic clk_ungated_i,
  input  logic rst_n,
  input  logic scan_cg_en_i,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic wake_i,
  output logic clk_gated_o,
  output logic core_sleep_o,
  output logic fetch_enable_o
);

  // Set by the first fetch enable pulse and held until reset
  logic fetch_enable_q;
  // Busy level one cycle late, so the core drains before the gate closes
  logic core_busy_q;
  // Final enable for the clock gate
  logic clock_en;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  // Both flops run on the free clock, they must see activity and the
  // fetch enable pulse while the core clock is off
  always_ff @(posedge clk_ungated_i or negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      if (fetch_enable_i) begin
        fetch_enable_q <= 1'b1;
      end
      core_busy_q <= core_busy_i;
    end
  end

  //////////////////////////////////////////////////
  // Clock enable and sleep
  //////////////////////////////////////////////////

  // Wake acts at once, so an interrupt reopens the gate in the same cycle
  assign clock_en = fetch_enable_q & (wake_i | core_busy_q);

  // Sleep means the core was started and has since been gated off,
  // which is the WFI state
  assign core_sleep_o   = fetch_enable_q & ~clock_en;
  assign fetch_enable_o = fetch_enable_q;

  // Core clock gate, the scan override acts only inside the gate
  clock_gate u_core_clock_gate (
    .clk_i        (clk_ungated_i),
    .en_i         (clock_en),
    .scan_cg_en_i (scan_cg_en_i),
    .clk_o        (clk_gated_o)
  );

  // The core clock stays off until fetch has been enabled
  a_no_clock_before_fetch: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    !fetch_enable_q |-> !clock_en);

  // While asleep the gate is closed
  a_sleep_gates_clock: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    core_sleep_o |-> !clock_en);

  // Sleep is only reached after the registered busy level has dropped
  a_sleep_not_busy: assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    core_sleep_o |-> !core_busy_q);

endmodule

`default_nettype wire

// File: power_top.sv
/*
 * Top level of the sleep and clock-gating subsystem. The interrupt wake
 * unit and the activity monitor work side by side and feed the sleep
 * controller, which produces the gated core clock and the sleep flag.
 */
`timescale 1ns/1ps
`default_nettype none

module power_top
  import power_pkg::*;
(
  input  logic                clk_ungated_i,
  input  logic                rst_n,
  // Interrupts
  input  logic [IRQ_W-1:0]    irq_i,
  input  logic [IRQ_W-1:0]    irq_enable_i,
  // Bus strobes, observed only
  input  logic                instr_req_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic                data_req_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  // Busy levels from fetch and the controller
  input  logic                if_busy_i,
  input  logic                ctrl_busy_i,
  // Control
  input  logic                fetch_enable_i,
  input  logic                scan_cg_en_i,
  // Results
  output logic                clk_gated_o,
  output logic                core_sleep_o,
  output logic                fetch_enable_o,
  output logic                irq_wake_o,
  output logic [IRQ_ID_W-1:0] irq_id_o
);

  // Wake level from the interrupt unit
  logic irq_wake;
  // Combined activity from the monitor
  logic core_busy;

  //////////////////////////////////////////////////
  // Side-by-side units
  //////////////////////////////////////////////////

  // The identity needs no further logic and leaves through the port
  irq_wake_unit u_irq_wake_unit (
    .irq_i        (irq_i),
    .irq_enable_i (irq_enable_i),
    .irq_wake_o   (irq_wake),
    .irq_id_o     (irq_id_o)
  );

  activity_monitor u_activity_monitor (
    .clk_ungated_i  (clk_ungated_i),
    .rst_n          (rst_n),
    .if_busy_i      (if_busy_i),
    .ctrl_busy_i    (ctrl_busy_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .core_busy_o    (core_busy)
  );

  // Sleep controller combines both results
  sleep_ctrl u_sleep_ctrl (
    .clk_ungated_i  (clk_ungated_i),
    .rst_n          (rst_n),
    .scan_cg_en_i   (scan_cg_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy),
    .wake_i         (irq_wake),
    .clk_gated_o    (clk_gated_o),
    .core_sleep_o   (core_sleep_o),
    .fetch_enable_o (fetch_enable_o)
  );

  assign irq_wake_o = irq_wake;

endmodule

`default_nettype wire

// File: tb_power_top.sv
/*
 * Testbench for the sleep and clock-gating top level. A table of rows is
 * applied in order; each row holds its inputs for some cycles and then the
 * sleep flag, fetch enable, wake, identity and gated clock edges are checked.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_power_top import power_pkg::*; ();

  // Most rows hold for six cycles, two of which settle before counting
  localparam int HOLD   = 6;
  localparam int RUN    = HOLD - 2;
  localparam int MARGIN = 20;
  localparam logic [31:0] LFSR_SEED = 32'h01acd696;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // Control bits of a row, fetch enable, grants and valids are one-cycle strobes
  localparam logic [9:0] FETCH     = 10'h001;
  localparam logic [9:0] SCAN      = 10'h002;
  localparam logic [9:0] IF_BUSY   = 10'h004;
  localparam logic [9:0] CTRL_BUSY = 10'h008;
  localparam logic [9:0] I_REQ     = 10'h010;
  localparam logic [9:0] I_GNT     = 10'h020;
  localparam logic [9:0] I_RVALID  = 10'h040;
  localparam logic [9:0] D_REQ     = 10'h080;
  localparam logic [9:0] D_GNT     = 10'h100;
  localparam logic [9:0] D_RVALID  = 10'h200;

  typedef struct packed {
    int                  hold;
    logic [9:0]          ctl;
    logic [IRQ_W-1:0]    irq;
    logic [IRQ_W-1:0]    irq_en;
    logic                exp_sleep;
    logic                exp_fe;
    logic                exp_wake;
    logic [IRQ_ID_W-1:0] exp_id;
    int                  exp_edges;
  } row_t;

  logic                clk_ungated_i;
  logic                rst_n;
  logic [IRQ_W-1:0]    irq_i;
  logic [IRQ_W-1:0]    irq_enable_i;
  logic                instr_req_i;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic                data_req_i;
  logic                data_gnt_i;
  logic                data_rvalid_i;
  logic                if_busy_i;
  logic                ctrl_busy_i;
  logic                fetch_enable_i;
  logic                scan_cg_en_i;
  logic                clk_gated_o;
  logic                core_sleep_o;
  logic                fetch_enable_o;
  logic                irq_wake_o;
  logic [IRQ_ID_W-1:0] irq_id_o;

  row_t        rows[$];
  string       names[$];
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          gated_edges;
  logic        count_on;
  int          cycles;
  int          cycle_limit;
  int          hold_sum;

  power_top uut (
    .clk_ungated_i  (clk_ungated_i),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .irq_enable_i   (irq_enable_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .if_busy_i      (if_busy_i),
    .ctrl_busy_i    (ctrl_busy_i),
    .fetch_enable_i (fetch_enable_i),
    .scan_cg_en_i   (scan_cg_en_i),
    .clk_gated_o    (clk_gated_o),
    .core_sleep_o   (core_sleep_o),
    .fetch_enable_o (fetch_enable_o),
    .irq_wake_o     (irq_wake_o),
    .irq_id_o       (irq_id_o)
  );

  always #5 clk_ungated_i = ~clk_ungated_i;

  // Gated edges are only counted inside the window of a row
  always @(posedge clk_gated_o) begin
    if (count_on) begin
      gated_edges++;
    end
  end

  // Run limit, twice the table length plus room for reset
  always @(posedge clk_ungated_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing the table", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and random words
  //////////////////////////////////////////////////

  // Fast lines from the top down, then external, software and timer
  function automatic logic [IRQ_ID_W-1:0] expected_id(input logic [IRQ_W-1:0] masked);
    logic [IRQ_ID_W-1:0] id;
    logic                found;
    id    = '0;
    found = 1'b0;
    for (int b = IRQ_W - 1; b >= FAST_LO; b--) begin
      if (!found && masked[b]) begin
        id    = IRQ_ID_W'(b);
        found = 1'b1;
      end
    end
    if (!found) begin
      if (masked[IRQ_MEI]) begin
        id = IRQ_ID_W'(IRQ_MEI);
      end else if (masked[IRQ_MSI]) begin
        id = IRQ_ID_W'(IRQ_MSI);
      end else if (masked[IRQ_MTI]) begin
        id = IRQ_ID_W'(IRQ_MTI);
      end
    end
    return id;
  endfunction

  // One step of a right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  // Each bit of the word costs one LFSR step
  task automatic lfsr_word(output logic [IRQ_W-1:0] w);
    for (int i = 0; i < IRQ_W; i++) begin
      w[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic ctl_has(input logic [9:0] ctl, input logic [9:0] mask);
    return (ctl & mask) != '0;
  endfunction

  //////////////////////////////////////////////////
  // Table
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input int hold, input logic [9:0] ctl,
                         input logic [IRQ_W-1:0] irq, input logic [IRQ_W-1:0] irq_en,
                         input logic exp_sleep, input logic exp_fe, input logic exp_wake,
                         input logic [IRQ_ID_W-1:0] exp_id, input int exp_edges);
    row_t r;
    r.hold      = hold;
    r.ctl       = ctl;
    r.irq       = irq;
    r.irq_en    = irq_en;
    r.exp_sleep = exp_sleep;
    r.exp_fe    = exp_fe;
    r.exp_wake  = exp_wake;
    r.exp_id    = exp_id;
    r.exp_edges = exp_edges;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // The core is asleep here, so only wake decides whether the clock runs
  task automatic add_lfsr_row(input string name, input logic [IRQ_W-1:0] en_mask);
    logic [IRQ_W-1:0] irq;
    logic [IRQ_W-1:0] en;
    logic [IRQ_W-1:0] masked;
    logic             wake;
    lfsr_word(irq);
    lfsr_word(en);
    en     = en & en_mask;
    masked = irq & en;
    wake   = |masked;
    add_row(name, HOLD, '0, irq, en, !wake, 1'b1, wake, expected_id(masked), wake ? RUN : 0);
  endtask

  task automatic build_table();
    add_row("busy before fetch", HOLD, IF_BUSY | CTRL_BUSY, '0, '0,
            1'b0, 1'b0, 1'b0, 5'd0, 0);
    add_row("fetch pulse with if busy", HOLD, FETCH | IF_BUSY, '0, '0,
            1'b0, 1'b1, 1'b0, 5'd0, RUN);
    add_row("ctrl busy", HOLD, CTRL_BUSY, '0, '0, 1'b0, 1'b1, 1'b0, 5'd0, RUN);
    add_row("busy falls", HOLD, '0, '0, '0, 1'b1, 1'b1, 1'b0, 5'd0, 0);
    add_row("instr request pending", HOLD, I_REQ, '0, '0, 1'b0, 1'b1, 1'b0, 5'd0, RUN);
    add_row("data request pending", HOLD, D_REQ, '0, '0, 1'b0, 1'b1, 1'b0, 5'd0, RUN);
    add_row("data grant outstanding", 8, D_GNT, '0, '0, 1'b0, 1'b1, 1'b0, 5'd0, 6);
    add_row("data valid retires", HOLD, D_RVALID, '0, '0, 1'b1, 1'b1, 1'b0, 5'd0, 0);
    add_row("instr grant outstanding", 8, I_GNT, '0, '0, 1'b0, 1'b1, 1'b0, 5'd0, 6);
    add_row("instr valid retires", HOLD, I_RVALID, '0, '0, 1'b1, 1'b1, 1'b0, 5'd0, 0);
    add_row("masked standard irqs", HOLD, '0, 32'h0000_0888, 32'hFFFF_0000,
            1'b1, 1'b1, 1'b0, 5'd0, 0);
    add_row("timer irq", HOLD, '0, 32'h0000_0080, '1, 1'b0, 1'b1, 1'b1, 5'd7, RUN);
    add_row("software over timer", HOLD, '0, 32'h0000_0088, '1, 1'b0, 1'b1, 1'b1, 5'd3, RUN);
    add_row("external first", HOLD, '0, 32'h0000_0888, '1, 1'b0, 1'b1, 1'b1, 5'd11, RUN);
    add_row("fast over external", HOLD, '0, 32'h0001_0800, '1, 1'b0, 1'b1, 1'b1, 5'd16, RUN);
    add_row("highest fast wins", HOLD, '0, 32'hA5A5_0888, 32'h7FFF_FFFF,
            1'b0, 1'b1, 1'b1, 5'd29, RUN);
    add_row("reserved bits wake only", HOLD, '0, 32'h0000_F777, '1,
            1'b0, 1'b1, 1'b1, 5'd0, RUN);
    add_lfsr_row("lfsr word a", '1);
    add_lfsr_row("lfsr word b", '1);
    add_lfsr_row("lfsr standard c", 32'h0000_0888);
    add_lfsr_row("lfsr standard d", 32'h0000_0888);
    add_row("scan override asleep", HOLD, SCAN, '0, '0, 1'b1, 1'b1, 1'b0, 5'd0, RUN);
    add_row("scan released", HOLD, '0, '0, '0, 1'b1, 1'b1, 1'b0, 5'd0, 0);
  endtask

  //////////////////////////////////////////////////
  // Row driver and checks
  //////////////////////////////////////////////////

  task automatic check_hex(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the last edge of the row
  task automatic apply_row(input int idx);
    row_t r;
    int   errors_before;
    r             = rows[idx];
    errors_before = errors;
    irq_i          = r.irq;
    irq_enable_i   = r.irq_en;
    fetch_enable_i = ctl_has(r.ctl, FETCH);
    scan_cg_en_i   = ctl_has(r.ctl, SCAN);
    if_busy_i      = ctl_has(r.ctl, IF_BUSY);
    ctrl_busy_i    = ctl_has(r.ctl, CTRL_BUSY);
    instr_req_i    = ctl_has(r.ctl, I_REQ);
    instr_gnt_i    = ctl_has(r.ctl, I_GNT);
    instr_rvalid_i = ctl_has(r.ctl, I_RVALID);
    data_req_i     = ctl_has(r.ctl, D_REQ);
    data_gnt_i     = ctl_has(r.ctl, D_GNT);
    data_rvalid_i  = ctl_has(r.ctl, D_RVALID);
    gated_edges    = 0;
    @(posedge clk_ungated_i);
    #1;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    // Second cycle lets the registered busy level and the latch settle
    @(posedge clk_ungated_i);
    #1;
    count_on = 1'b1;
    repeat (r.hold - 2) @(posedge clk_ungated_i);
    #1;
    count_on = 1'b0;
    check_hex("core_sleep_o", 32'(core_sleep_o), 32'(r.exp_sleep));
    check_hex("fetch_enable_o", 32'(fetch_enable_o), 32'(r.exp_fe));
    check_hex("irq_wake_o", 32'(irq_wake_o), 32'(r.exp_wake));
    check_hex("irq_id_o", 32'(irq_id_o), 32'(r.exp_id));
    check_hex("clk_gated_o edges", gated_edges, r.exp_edges);
    if (errors == errors_before) begin
      $display("row %0d %s: ok", idx, names[idx]);
    end else begin
      $display("row %0d %s: FAILED", idx, names[idx]);
    end
  endtask

  initial begin
    clk_ungated_i  = 1'b0;
    rst_n          = 1'b0;
    irq_i          = '0;
    irq_enable_i   = '0;
    instr_req_i    = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    data_req_i     = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    if_busy_i      = 1'b0;
    ctrl_busy_i    = 1'b0;
    fetch_enable_i = 1'b0;
    scan_cg_en_i   = 1'b0;
    errors         = 0;
    checks         = 0;
    gated_edges    = 0;
    count_on       = 1'b0;
    cycles         = 0;
    lfsr_state     = LFSR_SEED;
    build_table();
    hold_sum = 0;
    foreach (rows[i]) begin
      hold_sum += rows[i].hold;
    end
    cycle_limit = 2 * hold_sum + MARGIN;
    repeat (2) @(posedge clk_ungated_i);
    #1;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      apply_row(i);
    end
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
power_pkg.sv
clock_gate.sv
irq_wake_unit.sv
activity_monitor.sv
sleep_ctrl.sv
power_top.sv
tb_power_top.sv

// File: Makefile
# Verilator simulation of the sleep and clock-gating subsystem
TOP := tb_power_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, verdict from sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then \
	  echo "TEST FAILED"; exit 1; \
	fi
	@grep -q "Finished with no errors" sim.log || \
	  { echo "TEST FAILED: no verdict in sim.log"; exit 1; }
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log
